//--- src/exec_pkg.sv
package exec_pkg;

    localparam int DATA_W    = 16;
    localparam int PNUM_W    = 6;
    localparam int NUM_PREGS = 64;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_PASS = 3'd5   // Source 1 straight through.
    } alu_op_e;

    // Flag log codes. 2'b00 means never written since reset.
    localparam logic [1:0] FLAG_ZERO = 2'b11;
    localparam logic [1:0] FLAG_NEG  = 2'b01;
    localparam logic [1:0] FLAG_POS  = 2'b10;

    typedef struct packed {
        alu_op_e           op;
        logic [PNUM_W-1:0] src1;
        logic [PNUM_W-1:0] src2;
        logic [PNUM_W-1:0] dst;
        logic              wr_en;
        logic [1:0]        brn;
    } uop_t;

    typedef struct packed {
        logic [PNUM_W-1:0] dst;
        logic              wr_en;
        logic [DATA_W-1:0] data;
        logic [1:0]        brn_rslt;
    } comp_t;

endpackage

//--- src/uop_queue.sv
`timescale 1ns/1ps

module uop_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Wrap at DEPTH, which need not be a power of two.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;   // Idle or push and pop together.
            endcase
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // A push into a full queue means the producer's credit loop is broken.
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("uop_queue: push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
        else $error("uop_queue: pop while empty");

endmodule

//--- src/credit_counter.sv
`timescale 1ns/1ps

module credit_counter #(
    parameter int MAX = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic grant,
    input  logic spend,
    output logic avail
);

    // One spare bit so an over-grant is visible.
    localparam int CNT_W = $clog2(MAX + 1) + 1;

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;   // No credits until the ROB grants.
        end else begin
            case ({grant, spend})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assign avail = (count != '0);

    a_count_max: assert property (@(posedge clk) disable iff (!rst_n) count <= CNT_W'(MAX))
        else $error("credit_counter: count above MAX");

    a_spend_zero: assert property (@(posedge clk) disable iff (!rst_n) spend |-> count != '0)
        else $error("credit_counter: spend with no credit");

endmodule

//--- src/issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        iq_empty,
    input  logic                        cq_full,
    output logic                        iq_pop,
    input  exec_pkg::uop_t              cur_uop,
    output logic [exec_pkg::PNUM_W-1:0] rd_src1,
    output logic [exec_pkg::PNUM_W-1:0] rd_src2,
    output logic [1:0]                  brn,
    input  logic [exec_pkg::DATA_W-1:0] rd1_data,
    input  logic [exec_pkg::DATA_W-1:0] rd2_data,
    input  logic [1:0]                  brn_rslt,
    output exec_pkg::alu_op_e           alu_op,
    output logic [exec_pkg::DATA_W-1:0] alu_a,
    output logic [exec_pkg::DATA_W-1:0] alu_b,
    input  logic [exec_pkg::DATA_W-1:0] alu_y,
    output logic                        wr_valid,
    output logic [exec_pkg::PNUM_W-1:0] wr_pnum,
    output logic [exec_pkg::DATA_W-1:0] wr_data,
    output logic                        cq_push,
    output exec_pkg::comp_t             cq_data
);

    typedef enum logic [1:0] {IDLE, READ, EXEC} state_e;

    state_e                      state;
    exec_pkg::uop_t              uop_q;
    logic [exec_pkg::DATA_W-1:0] a_q;
    logic [exec_pkg::DATA_W-1:0] b_q;
    logic [1:0]                  brn_q;

    // Only pop when the completion has somewhere to go.
    assign iq_pop = (state == IDLE) && !iq_empty && !cq_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (iq_pop) state <= READ;
                READ:    state <= EXEC;
                EXEC:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (iq_pop) uop_q <= cur_uop;
        if (state == READ) begin
            a_q   <= rd1_data;
            b_q   <= rd2_data;
            brn_q <= brn_rslt;
        end
    end

    assign rd_src1 = uop_q.src1;   // PRF read is combinational.
    assign rd_src2 = uop_q.src2;
    assign brn     = uop_q.brn;

    assign alu_op = uop_q.op;
    assign alu_a  = a_q;
    assign alu_b  = b_q;

    assign wr_valid = (state == EXEC) && uop_q.wr_en;
    assign wr_pnum  = uop_q.dst;
    assign wr_data  = alu_y;

    assign cq_push          = (state == EXEC);
    assign cq_data.dst      = uop_q.dst;
    assign cq_data.wr_en    = uop_q.wr_en;
    assign cq_data.data     = alu_y;
    assign cq_data.brn_rslt = brn_q;

    // The pop reserved a slot in the completion queue.
    a_push_room: assert property (@(posedge clk) disable iff (!rst_n) cq_push |-> !cq_full)
        else $error("issue_ctrl: completion push into a full queue");

endmodule

//--- src/prf.sv
`timescale 1ns/1ps

module prf (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [exec_pkg::PNUM_W-1:0] rd1_pnum,
    input  logic [exec_pkg::PNUM_W-1:0] rd2_pnum,
    input  logic [1:0]                  brn,
    output logic [exec_pkg::DATA_W-1:0] rd1_data,
    output logic [exec_pkg::DATA_W-1:0] rd2_data,
    output logic [1:0]                  brn_rslt,
    input  logic                        wr0_valid,
    input  logic [exec_pkg::PNUM_W-1:0] wr0_pnum,
    input  logic [exec_pkg::DATA_W-1:0] wr0_data,
    input  logic                        wr1_valid,
    input  logic [exec_pkg::PNUM_W-1:0] wr1_pnum,
    input  logic [exec_pkg::DATA_W-1:0] wr1_data
);

    logic [exec_pkg::DATA_W-1:0] regs  [exec_pkg::NUM_PREGS];
    logic [1:0]                  flags [exec_pkg::NUM_PREGS];
    logic                        wr1_blocked;

    function automatic logic [1:0] flag_of(input logic [exec_pkg::DATA_W-1:0] d);
        if (d == '0)
            return exec_pkg::FLAG_ZERO;
        else if (d[exec_pkg::DATA_W-1])
            return exec_pkg::FLAG_NEG;
        else
            return exec_pkg::FLAG_POS;
    endfunction

    assign rd1_data = regs[rd1_pnum];
    assign rd2_data = regs[rd2_pnum];

    // Branch result always comes from source 1.
    assign brn_rslt = (brn != 2'b00) ? flags[rd1_pnum] : 2'b00;

    // ALU port wins a same-entry collision.
    assign wr1_blocked = wr0_valid && (wr1_pnum == wr0_pnum);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < exec_pkg::NUM_PREGS; i++) begin
                regs[i]  <= '0;
                flags[i] <= 2'b00;
            end
        end else begin
            if (wr0_valid) begin
                regs[wr0_pnum]  <= wr0_data;
                flags[wr0_pnum] <= flag_of(wr0_data);
            end
            if (wr1_valid && !wr1_blocked) begin
                regs[wr1_pnum]  <= wr1_data;
                flags[wr1_pnum] <= flag_of(wr1_data);
            end
        end
    end

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
    input  exec_pkg::alu_op_e           op,
    input  logic [exec_pkg::DATA_W-1:0] a,
    input  logic [exec_pkg::DATA_W-1:0] b,
    output logic [exec_pkg::DATA_W-1:0] y
);

    // Add and subtract wrap at the data width.
    always_comb begin
        case (op)
            exec_pkg::OP_ADD:  y = a + b;
            exec_pkg::OP_SUB:  y = a - b;
            exec_pkg::OP_AND:  y = a & b;
            exec_pkg::OP_OR:   y = a | b;
            exec_pkg::OP_XOR:  y = a ^ b;
            exec_pkg::OP_PASS: y = a;
            default:           y = '0;   // Unused encodings.
        endcase
    end

endmodule

//--- src/exec_top.sv
`timescale 1ns/1ps

module exec_top #(
    parameter int IQ_DEPTH = 4,
    parameter int CQ_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        uop_valid,
    input  logic [2:0]                  uop_op,
    input  logic [exec_pkg::PNUM_W-1:0] uop_src1,
    input  logic [exec_pkg::PNUM_W-1:0] uop_src2,
    input  logic [exec_pkg::PNUM_W-1:0] uop_dst,
    input  logic                        uop_wr_en,
    input  logic [1:0]                  uop_brn,
    output logic                        uop_credit,
    input  logic                        comp_credit,
    output logic                        comp_valid,
    output logic [exec_pkg::PNUM_W-1:0] comp_dst,
    output logic                        comp_wr_en,
    output logic [exec_pkg::DATA_W-1:0] comp_data,
    output logic [1:0]                  comp_brn_rslt,
    input  logic                        ld_wr_valid,
    input  logic [exec_pkg::PNUM_W-1:0] ld_wr_pnum,
    input  logic [exec_pkg::DATA_W-1:0] ld_wr_data
);

    exec_pkg::uop_t              uop_in;
    exec_pkg::uop_t              iq_head;
    logic                        iq_empty;
    logic                        iq_pop;
    exec_pkg::comp_t             cq_data;
    exec_pkg::comp_t             cq_head;
    logic                        cq_push;
    logic                        cq_empty;
    logic                        cq_full;
    logic                        cred_avail;
    logic                        comp_pop;
    logic [exec_pkg::PNUM_W-1:0] rd_src1;
    logic [exec_pkg::PNUM_W-1:0] rd_src2;
    logic [1:0]                  brn;
    logic [exec_pkg::DATA_W-1:0] rd1_data;
    logic [exec_pkg::DATA_W-1:0] rd2_data;
    logic [1:0]                  brn_rslt;
    exec_pkg::alu_op_e           alu_op;
    logic [exec_pkg::DATA_W-1:0] alu_a;
    logic [exec_pkg::DATA_W-1:0] alu_b;
    logic [exec_pkg::DATA_W-1:0] alu_y;
    logic                        wr_valid;
    logic [exec_pkg::PNUM_W-1:0] wr_pnum;
    logic [exec_pkg::DATA_W-1:0] wr_data;

    assign uop_in.op    = exec_pkg::alu_op_e'(uop_op);
    assign uop_in.src1  = uop_src1;
    assign uop_in.src2  = uop_src2;
    assign uop_in.dst   = uop_dst;
    assign uop_in.wr_en = uop_wr_en;
    assign uop_in.brn   = uop_brn;

    assign uop_credit = iq_pop;   // One credit back per pop.

    // Head leaves only with a ROB credit in hand.
    assign comp_pop      = !cq_empty && cred_avail;
    assign comp_valid    = comp_pop;
    assign comp_dst      = cq_head.dst;
    assign comp_wr_en    = cq_head.wr_en;
    assign comp_data     = cq_head.data;
    assign comp_brn_rslt = cq_head.brn_rslt;

    uop_queue #(
        .payload_t (exec_pkg::uop_t),
        .DEPTH     (IQ_DEPTH)
    ) issue_q (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (uop_valid),
        .push_data (uop_in),
        .pop       (iq_pop),
        .head      (iq_head),
        .empty     (iq_empty),
        .full      ()   // Dispatcher credits keep it from filling.
    );

    uop_queue #(
        .payload_t (exec_pkg::comp_t),
        .DEPTH     (CQ_DEPTH)
    ) comp_q (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (cq_push),
        .push_data (cq_data),
        .pop       (comp_pop),
        .head      (cq_head),
        .empty     (cq_empty),
        .full      (cq_full)
    );

    credit_counter #(
        .MAX (CQ_DEPTH)
    ) u_rob_credit (
        .clk   (clk),
        .rst_n (rst_n),
        .grant (comp_credit),
        .spend (comp_pop),
        .avail (cred_avail)
    );

    issue_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .iq_empty (iq_empty),
        .cq_full  (cq_full),
        .iq_pop   (iq_pop),
        .cur_uop  (iq_head),
        .rd_src1  (rd_src1),
        .rd_src2  (rd_src2),
        .brn      (brn),
        .rd1_data (rd1_data),
        .rd2_data (rd2_data),
        .brn_rslt (brn_rslt),
        .alu_op   (alu_op),
        .alu_a    (alu_a),
        .alu_b    (alu_b),
        .alu_y    (alu_y),
        .wr_valid (wr_valid),
        .wr_pnum  (wr_pnum),
        .wr_data  (wr_data),
        .cq_push  (cq_push),
        .cq_data  (cq_data)
    );

    prf u_prf (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd1_pnum  (rd_src1),
        .rd2_pnum  (rd_src2),
        .brn       (brn),
        .rd1_data  (rd1_data),
        .rd2_data  (rd2_data),
        .brn_rslt  (brn_rslt),
        .wr0_valid (wr_valid),
        .wr0_pnum  (wr_pnum),
        .wr0_data  (wr_data),
        .wr1_valid (ld_wr_valid),
        .wr1_pnum  (ld_wr_pnum),
        .wr1_data  (ld_wr_data)
    );

    alu u_alu (
        .op (alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

endmodule

//--- verif/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Shadow register file kept in dispatch order.
logic [exec_pkg::DATA_W-1:0] shadow_regs  [exec_pkg::NUM_PREGS];
logic [1:0]                  shadow_flags [exec_pkg::NUM_PREGS];

typedef struct packed {
    logic [exec_pkg::PNUM_W-1:0] dst;
    logic                        wr_en;
    logic [exec_pkg::DATA_W-1:0] data;
    logic [1:0]                  brn_rslt;
} exp_rec_t;

exp_rec_t exp_q [$];   // Expected completions in dispatch order.

function automatic logic [1:0] flag_code(input logic [exec_pkg::DATA_W-1:0] d);
    if (d == '0)
        return 2'b11;
    else if (d[exec_pkg::DATA_W-1])
        return 2'b01;   // Negative.
    else
        return 2'b10;
endfunction

function automatic logic [exec_pkg::DATA_W-1:0] ref_alu(input logic [2:0] op,
                                                        input logic [exec_pkg::DATA_W-1:0] a,
                                                        input logic [exec_pkg::DATA_W-1:0] b);
    case (op)
        exec_pkg::OP_ADD:  return a + b;
        exec_pkg::OP_SUB:  return a - b;
        exec_pkg::OP_AND:  return a & b;
        exec_pkg::OP_OR:   return a | b;
        exec_pkg::OP_XOR:  return a ^ b;
        exec_pkg::OP_PASS: return a;
        default:           return '0;
    endcase
endfunction

task automatic shadow_reset();
    for (int i = 0; i < exec_pkg::NUM_PREGS; i++) begin
        shadow_regs[i]  = '0;
        shadow_flags[i] = 2'b00;   // Never written.
    end
endtask

task automatic shadow_write(input logic [exec_pkg::PNUM_W-1:0] pnum,
                            input logic [exec_pkg::DATA_W-1:0] data);
    shadow_regs[pnum]  = data;
    shadow_flags[pnum] = flag_code(data);
endtask

task automatic predict_uop(input logic [2:0] op, input logic [exec_pkg::PNUM_W-1:0] s1,
                           input logic [exec_pkg::PNUM_W-1:0] s2,
                           input logic [exec_pkg::PNUM_W-1:0] dst,
                           input logic wr, input logic [1:0] brn);
    exp_rec_t rec;
    rec.dst      = dst;
    rec.wr_en    = wr;
    rec.data     = ref_alu(op, shadow_regs[s1], shadow_regs[s2]);
    rec.brn_rslt = (brn != 2'b00) ? shadow_flags[s1] : 2'b00;
    if (wr) shadow_write(dst, rec.data);
    exp_q.push_back(rec);
endtask

`endif

//--- verif/tb_exec_top.sv
`timescale 1ns/1ps

module tb_exec_top;

    localparam int IQ_DEPTH = 4;
    localparam int CQ_DEPTH = 4;
    localparam int TIMEOUT  = 400;   // Cycles per wait.

    logic                        clk;
    logic                        rst_n;
    logic                        uop_valid;
    logic [2:0]                  uop_op;
    logic [exec_pkg::PNUM_W-1:0] uop_src1;
    logic [exec_pkg::PNUM_W-1:0] uop_src2;
    logic [exec_pkg::PNUM_W-1:0] uop_dst;
    logic                        uop_wr_en;
    logic [1:0]                  uop_brn;
    logic                        uop_credit;
    logic                        comp_credit;
    logic                        comp_valid;
    logic [exec_pkg::PNUM_W-1:0] comp_dst;
    logic                        comp_wr_en;
    logic [exec_pkg::DATA_W-1:0] comp_data;
    logic [1:0]                  comp_brn_rslt;
    logic                        ld_wr_valid;
    logic [exec_pkg::PNUM_W-1:0] ld_wr_pnum;
    logic [exec_pkg::DATA_W-1:0] ld_wr_data;

    int errors;
    int checks;
    int credits;     // Dispatcher side.
    int rob_cnt;     // Mirror of the ROB credits held by the cluster.
    int sent;
    int pulses;
    int granted;
    int comp_seen;
    bit last_pop;
    bit aborted;

    `include "exec_model.svh"

    exec_top #(
        .IQ_DEPTH (IQ_DEPTH),
        .CQ_DEPTH (CQ_DEPTH)
    ) DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .uop_valid     (uop_valid),
        .uop_op        (uop_op),
        .uop_src1      (uop_src1),
        .uop_src2      (uop_src2),
        .uop_dst       (uop_dst),
        .uop_wr_en     (uop_wr_en),
        .uop_brn       (uop_brn),
        .uop_credit    (uop_credit),
        .comp_credit   (comp_credit),
        .comp_valid    (comp_valid),
        .comp_dst      (comp_dst),
        .comp_wr_en    (comp_wr_en),
        .comp_data     (comp_data),
        .comp_brn_rslt (comp_brn_rslt),
        .ld_wr_valid   (ld_wr_valid),
        .ld_wr_pnum    (ld_wr_pnum),
        .ld_wr_data    (ld_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %0h expected %0h",
                     $time, msg, actual, expected);
        end
    endtask

    task automatic match_completion();
        exp_rec_t rec;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Unexpected completion at %0t with no micro-op outstanding", $time);
        end else begin
            rec = exp_q.pop_front();
            check_val(32'(comp_dst), 32'(rec.dst), "comp_dst");
            check_val(32'(comp_wr_en), 32'(rec.wr_en), "comp_wr_en");
            check_val(32'(comp_data), 32'(rec.data), "comp_data");
            check_val(32'(comp_brn_rslt), 32'(rec.brn_rslt), "comp_brn_rslt");
        end
        comp_seen++;
    endtask

    task automatic send_uop(input logic [2:0] op, input logic [exec_pkg::PNUM_W-1:0] s1,
                            input logic [exec_pkg::PNUM_W-1:0] s2,
                            input logic [exec_pkg::PNUM_W-1:0] dst,
                            input logic wr, input logic [1:0] brn);
        uop_valid = 1'b1;
        uop_op    = op;
        uop_src1  = s1;
        uop_src2  = s2;
        uop_dst   = dst;
        uop_wr_en = wr;
        uop_brn   = brn;
        credits--;
        sent++;
        predict_uop(op, s1, s2, dst, wr, brn);
    endtask

    task automatic send_random_uop();
        logic [2:0] op;
        op = 3'($urandom % 6);
        send_uop(op, 6'($urandom % 16), 6'($urandom % 16), 6'($urandom % 16),
                 1'($urandom), 2'($urandom));
    endtask

    task automatic drive_load(input logic [exec_pkg::PNUM_W-1:0] pnum,
                              input logic [exec_pkg::DATA_W-1:0] data);
        ld_wr_valid = 1'b1;
        ld_wr_pnum  = pnum;
        ld_wr_data  = data;
    endtask

    // Sample outputs and drive inputs at the falling edge.
    task automatic tick(input int send_pct, input int grant_pct);
        bit popped;
        @(negedge clk);
        popped = uop_credit;
        if (comp_valid) match_completion();
        check_val(32'(comp_seen <= granted), 1, "more completions than credits granted");
        if (comp_valid) rob_cnt--;
        uop_valid   = 1'b0;
        comp_credit = 1'b0;
        ld_wr_valid = 1'b0;
        if (credits > 0 && int'($urandom % 100) < send_pct) send_random_uop();
        if (rob_cnt < CQ_DEPTH && int'($urandom % 100) < grant_pct) begin
            comp_credit = 1'b1;
            rob_cnt++;
            granted++;
        end
        // A returned credit is usable from the next cycle.
        if (popped) begin
            credits++;
            pulses++;
        end
        check_val(32'(credits >= 0 && credits <= IQ_DEPTH), 1, "dispatcher credit range");
        last_pop = popped;
    endtask

    task automatic wait_drained(input int grant_pct, input string what);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            tick(0, grant_pct);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            aborted = 1'b1;
            $display("Timeout while draining %s, %0d completions never arrived",
                     what, exp_q.size());
        end else begin
            check_val(credits, IQ_DEPTH, "dispatcher credits after drain");
        end
    endtask

    task automatic wait_for_pop();
        int n;
        n = 0;
        tick(0, 50);
        while (!last_pop && n < TIMEOUT) begin
            tick(0, 50);
            n++;
        end
        if (!last_pop) begin
            errors++;
            aborted = 1'b1;
            $display("Timeout waiting for the issue queue to pop a micro-op");
        end
    endtask

    task automatic run_reset_check();
        repeat (3) begin
            tick(0, 0);
            send_uop(exec_pkg::OP_PASS, 6'($urandom), 6'($urandom), 6'($urandom), 1'b0,
                     2'(1 + $urandom % 3));
        end
        wait_drained(50, "after reset");
    endtask

    task automatic run_random_batches();
        logic [exec_pkg::DATA_W-1:0] d;
        logic [exec_pkg::PNUM_W-1:0] p;
        for (int b = 0; b < 30 && !aborted; b++) begin
            repeat (1 + $urandom % 8) tick(60, 50);
            wait_drained(50, "random batch");
            repeat ($urandom % 3) begin
                tick(0, 0);
                p = 6'($urandom % 16);
                d = ($urandom % 4 == 0) ? '0 : 16'($urandom);
                drive_load(p, d);
                shadow_write(p, d);
            end
        end
    endtask

    // Load and ALU writeback to one entry on the same edge.
    task automatic run_collision();
        logic [exec_pkg::PNUM_W-1:0] x;
        for (int k = 0; k < 4 && !aborted; k++) begin
            x = 6'($urandom % 16);
            tick(0, 0);
            send_uop(3'($urandom % 6), 6'($urandom % 16), 6'($urandom % 16), x, 1'b1, 2'b00);
            wait_for_pop();
            if (!aborted) begin
                tick(0, 50);
                tick(0, 50);   // EXEC cycle.
                drive_load(x, ~shadow_regs[x]);   // The ALU write wins this entry.
                wait_drained(50, "collision");
                tick(0, 0);
                send_uop(exec_pkg::OP_PASS, x, 6'd0, x, 1'b0, 2'b01);
                wait_drained(50, "collision readback");
            end
        end
    endtask

    task automatic run_backpressure();
        repeat (80) tick(60, 0);
        check_val(credits, 0, "dispatcher credits under back-pressure");
        wait_drained(40, "after back-pressure");
    endtask

    initial begin
        void'($urandom(32'hb14b1b84));
        rst_n       = 1'b0;
        uop_valid   = 1'b0;
        uop_op      = '0;
        uop_src1    = '0;
        uop_src2    = '0;
        uop_dst     = '0;
        uop_wr_en   = 1'b0;
        uop_brn     = '0;
        comp_credit = 1'b0;
        ld_wr_valid = 1'b0;
        ld_wr_pnum  = '0;
        ld_wr_data  = '0;
        errors      = 0;
        checks      = 0;
        credits     = IQ_DEPTH;
        rob_cnt     = 0;
        sent        = 0;
        pulses      = 0;
        granted     = 0;
        comp_seen   = 0;
        last_pop    = 1'b0;
        aborted     = 1'b0;
        shadow_reset();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        run_reset_check();
        if (!aborted) run_random_batches();
        if (!aborted) run_collision();
        if (!aborted) run_backpressure();
        if (!aborted) begin
            check_val(pulses, sent, "uop_credit pulses against micro-ops sent");
            check_val(credits, IQ_DEPTH, "final dispatcher credits");
        end

        $display("Summary: %0d checks, %0d errors, %0d micro-ops, %0d completions",
                 checks, errors, sent, comp_seen);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
src/exec_pkg.sv
src/uop_queue.sv
src/credit_counter.sv
src/issue_ctrl.sv
src/prf.sv
src/alu.sv
src/exec_top.sv
verif/tb_exec_top.sv
+incdir+verif

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_exec_top -f list.f -o tb_exec_top

out=$(./obj_dir/tb_exec_top 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Test OK"
